// File: common/core_pkg.sv
package core_pkg;

    // datapath width of the integer core
    localparam int XLEN = 32;

    // width of the reorder buffer tag carried by execution records
    localparam int TAG_LEN = 4;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [TAG_LEN-1:0] tag_t;

    // operations seen by the back end
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_BEQ,
        OP_BNE,
        OP_MULT,
        OP_LOAD,
        OP_STORE
    } op_t;

    // issued alu or branch operation
    typedef struct packed {
        logic  valid;
        tag_t  rob_addr;
        op_t   op;
        word_t a;
        word_t b;
        word_t target;
    } alu_req_t;

    // issued multiply
    typedef struct packed {
        logic  valid;
        tag_t  rob_addr;
        word_t a;
        word_t b;
    } mult_req_t;

    // completion records
    typedef struct packed {
        logic  valid;
        tag_t  rob_addr;
        word_t result;
        logic  taken;
        word_t target;
    } alu_done_t;

    typedef struct packed {
        logic  valid;
        tag_t  rob_addr;
        word_t hi;
        word_t lo;
    } mult_done_t;

    // memory unit record with the effective address and load or store data
    typedef struct packed {
        logic  valid;
        tag_t  rob_addr;
        word_t addr;
        word_t data;
    } mem_done_t;

endpackage

// File: common/rob_pkg.sv
package rob_pkg;
    import core_pkg::*;

    // table geometry
    localparam int ROB_DEPTH    = 16;
    localparam int ROB_ADDR_LEN = TAG_LEN;

    // entries allocated and retired per cycle
    localparam int MACHINE_WIDTH = 2;
    localparam int RETIRE_WIDTH  = 2;

    // architectural register index
    localparam int REG_ADDR_LEN = 5;

    typedef logic [ROB_ADDR_LEN-1:0] rob_addr_t;
    // extra msb is the wrap bit
    typedef logic [ROB_ADDR_LEN:0]   rob_ptr_t;
    typedef logic [REG_ADDR_LEN-1:0] reg_addr_t;

    // one instruction from rename
    typedef struct packed {
        logic      valid;
        reg_addr_t dst;
        word_t     pc_plus8;
        op_t       op;
    } rename_slot_t;

    // table entry
    typedef struct packed {
        logic        complete;
        reg_addr_t   dst;
        word_t       pc_plus8;
        op_t         op;
        logic [63:0] data;
        word_t       mem_addr;
        logic        taken;
        word_t       target;
    } rob_entry_t;

    // one retired instruction
    typedef struct packed {
        logic        valid;
        rob_addr_t   rob_addr;
        reg_addr_t   dst;
        logic [63:0] data;
        word_t       pc_plus8;
    } retire_slot_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // memory write of a retired store
    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } store_req_t;

endpackage

// File: rob/rob.sv
module rob
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  rename_slot_t [MACHINE_WIDTH-1:0]  rename_in,
    input  alu_done_t                         alu_done,
    input  mult_done_t                        mult_done,
    input  mem_done_t                         mem_done,
    input  logic                              store_busy,
    output rob_addr_t    [MACHINE_WIDTH-1:0]  alloc_addr,
    output logic                              rob_full,
    output retire_slot_t [RETIRE_WIDTH-1:0]   retire_out,
    output redirect_t                         redirect,
    output store_req_t                        store_issue
);

    rob_entry_t table_q [ROB_DEPTH];
    // table with this cycle's completions folded in
    rob_entry_t merged  [ROB_DEPTH];

    rob_ptr_t head_q, tail_q;
    rob_ptr_t head_d, tail_d;
    rob_ptr_t occupancy;

    logic [MACHINE_WIDTH-1:0] alloc_en;

    // completions land before retire looks at the table
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            merged[i] = table_q[i];
            if (alu_done.valid && alu_done.rob_addr == rob_addr_t'(i)) begin
                merged[i].complete = 1'b1;
                merged[i].data     = {32'b0, alu_done.result};
                merged[i].taken    = alu_done.taken;
                merged[i].target   = alu_done.target;
            end
            if (mult_done.valid && mult_done.rob_addr == rob_addr_t'(i)) begin
                merged[i].complete = 1'b1;
                merged[i].data     = {mult_done.hi, mult_done.lo};
            end
            if (mem_done.valid && mem_done.rob_addr == rob_addr_t'(i)) begin
                merged[i].complete = 1'b1;
                merged[i].data     = {32'b0, mem_done.data};
                merged[i].mem_addr = mem_done.addr;
            end
        end
    end

    // in-order retire walk from the head
    always_comb begin
        rob_ptr_t   ptr;
        rob_entry_t ent;
        logic       stop;
        logic       store_sent;
        logic       is_branch;
        logic       is_store;

        ptr         = head_q;
        stop        = 1'b0;
        store_sent  = 1'b0;
        retire_out  = '0;
        redirect    = '0;
        store_issue = '0;

        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            ent       = merged[ptr[ROB_ADDR_LEN-1:0]];
            is_branch = ent.op inside {OP_BEQ, OP_BNE};
            is_store  = ent.op == OP_STORE;
            // a store waits while the port is busy, and only one goes per cycle
            if (stop || ptr == tail_q || !ent.complete ||
                    (is_store && (store_busy || store_sent))) begin
                stop = 1'b1;
            end else begin
                retire_out[i].valid    = 1'b1;
                retire_out[i].rob_addr = ptr[ROB_ADDR_LEN-1:0];
                retire_out[i].dst      = ent.dst;
                retire_out[i].pc_plus8 = ent.pc_plus8;
                // branches write the link value
                retire_out[i].data     = is_branch ? {32'b0, ent.pc_plus8} : ent.data;

                if (is_store) begin
                    store_issue.valid = 1'b1;
                    store_issue.addr  = ent.mem_addr;
                    store_issue.data  = ent.data[XLEN-1:0];
                    store_sent        = 1'b1;
                end

                if (is_branch && ent.taken) begin
                    redirect.valid  = 1'b1;
                    redirect.target = ent.target;
                    stop            = 1'b1;
                end
                ptr = ptr + 1'b1;
            end
        end
        head_d = ptr;
    end

    assign occupancy = tail_q - head_q;
    assign rob_full  = occupancy > rob_ptr_t'(ROB_DEPTH - MACHINE_WIDTH);

    // allocation in slot order is dropped on a redirect
    always_comb begin
        rob_ptr_t slot_ptr;
        logic     open;

        tail_d = tail_q;
        open   = !rob_full && !redirect.valid;
        for (int s = 0; s < MACHINE_WIDTH; s++) begin
            slot_ptr      = tail_q + rob_ptr_t'(s);
            alloc_addr[s] = slot_ptr[ROB_ADDR_LEN-1:0];
            alloc_en[s]   = open && rename_in[s].valid;
            open          = alloc_en[s];
            if (alloc_en[s]) begin
                tail_d = tail_d + 1'b1;
            end
        end
        // younger entries vanish behind a taken branch
        if (redirect.valid) begin
            tail_d = head_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_d;
            tail_q <= tail_d;
        end
    end

    // completions written back, then new entries at the tail
    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            table_q[i] <= merged[i];
        end
        for (int s = 0; s < MACHINE_WIDTH; s++) begin
            if (alloc_en[s]) begin
                table_q[alloc_addr[s]]          <= '0;
                table_q[alloc_addr[s]].dst      <= rename_in[s].dst;
                table_q[alloc_addr[s]].pc_plus8 <= rename_in[s].pc_plus8;
                table_q[alloc_addr[s]].op       <= rename_in[s].op;
            end
        end
    end

endmodule

// File: hdl/alu_unit.sv
module alu_unit
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  alu_req_t  alu_req,
    output alu_done_t alu_done
);

    word_t result;
    logic  taken;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (alu_req.op)
            OP_ADD: result = alu_req.a + alu_req.b;
            OP_SUB: result = alu_req.a - alu_req.b;
            OP_AND: result = alu_req.a & alu_req.b;
            OP_OR:  result = alu_req.a | alu_req.b;
            OP_XOR: result = alu_req.a ^ alu_req.b;
            OP_SLT: begin
                // signed compare gives 0 or 1
                result = {{(XLEN-1){1'b0}}, $signed(alu_req.a) < $signed(alu_req.b)};
            end
            OP_BEQ: taken = alu_req.a == alu_req.b;
            OP_BNE: taken = alu_req.a != alu_req.b;
            default: begin
                result = '0;
                taken  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_done.valid <= 1'b0;
        end else begin
            alu_done.valid    <= alu_req.valid;
            alu_done.rob_addr <= alu_req.rob_addr;
            alu_done.result   <= result;
            alu_done.taken    <= taken;
            // target goes through untouched for the redirect
            alu_done.target   <= alu_req.target;
        end
    end

endmodule

// File: hdl/mult_unit.sv
module mult_unit
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  mult_req_t  mult_req,
    output mult_done_t mult_done
);

    // stage 1 partial products on 16-bit halves
    logic        s1_valid;
    tag_t        s1_addr;
    logic [31:0] pp_hh;
    logic [32:0] pp_hl;
    logic [32:0] pp_lh;
    logic [31:0] pp_ll;
    logic [63:0] product;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= mult_req.valid;
            s1_addr  <= mult_req.rob_addr;
            // upper halves signed, lower halves unsigned
            pp_hh    <= $signed(mult_req.a[31:16]) * $signed(mult_req.b[31:16]);
            pp_hl    <= $signed(mult_req.a[31:16]) * $signed({1'b0, mult_req.b[15:0]});
            pp_lh    <= $signed({1'b0, mult_req.a[15:0]}) * $signed(mult_req.b[31:16]);
            pp_ll    <= mult_req.a[15:0] * mult_req.b[15:0];
        end
    end

    // sign-extend and align the cross terms
    assign product = {pp_hh, 32'b0}
                   + {{15{pp_hl[32]}}, pp_hl, 16'b0}
                   + {{15{pp_lh[32]}}, pp_lh, 16'b0}
                   + {32'b0, pp_ll};

    // stage 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mult_done.valid <= 1'b0;
        end else begin
            mult_done.valid    <= s1_valid;
            mult_done.rob_addr <= s1_addr;
            mult_done.hi       <= product[63:32];
            mult_done.lo       <= product[31:0];
        end
    end

endmodule

// File: hdl/store_port.sv
module store_port
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  store_req_t store_issue,
    input  logic       d_data_ok,
    output store_req_t mwrite,
    output logic       store_busy
);

    typedef enum logic {
        IDLE,
        WAIT_ACK
    } state_t;

    state_t      state;
    logic [31:0] addr_q;
    logic [31:0] data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (store_issue.valid) begin
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (d_data_ok) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // write held stable until memory acknowledges
    always_ff @(posedge clk) begin
        if (state == IDLE && store_issue.valid) begin
            addr_q <= store_issue.addr;
            data_q <= store_issue.data;
        end
    end

    assign store_busy   = state == WAIT_ACK;
    assign mwrite.valid = store_busy;
    assign mwrite.addr  = addr_q;
    assign mwrite.data  = data_q;

endmodule

// File: hdl/backend_top.sv
module backend_top
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  rename_slot_t [MACHINE_WIDTH-1:0]  rename_in,
    input  alu_req_t                          alu_req,
    input  mult_req_t                         mult_req,
    input  mem_done_t                         mem_done,
    input  logic                              d_data_ok,
    output rob_addr_t    [MACHINE_WIDTH-1:0]  alloc_addr,
    output logic                              rob_full,
    output retire_slot_t [RETIRE_WIDTH-1:0]   retire_out,
    output redirect_t                         redirect,
    output store_req_t                        mwrite
);

    alu_done_t  alu_done;
    mult_done_t mult_done;
    store_req_t store_issue;
    logic       store_busy;

    rob i_rob (
        .clk         (clk),
        .rst_n       (rst_n),
        .rename_in   (rename_in),
        .alu_done    (alu_done),
        .mult_done   (mult_done),
        .mem_done    (mem_done),
        .store_busy  (store_busy),
        .alloc_addr  (alloc_addr),
        .rob_full    (rob_full),
        .retire_out  (retire_out),
        .redirect    (redirect),
        .store_issue (store_issue)
    );

    alu_unit i_alu_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .alu_req  (alu_req),
        .alu_done (alu_done)
    );

    mult_unit i_mult_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .mult_req  (mult_req),
        .mult_done (mult_done)
    );

    store_port i_store_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_issue (store_issue),
        .d_data_ok   (d_data_ok),
        .mwrite      (mwrite),
        .store_busy  (store_busy)
    );

endmodule

// File: bench/backend_props.sv
module backend_props
    import core_pkg::*;
    import rob_pkg::*;
(
    input logic                            clk,
    input logic                            rst_n,
    input retire_slot_t [RETIRE_WIDTH-1:0] retire_out,
    input redirect_t                       redirect,
    input store_req_t                      mwrite,
    input logic                            d_data_ok
);

    // retire pairs sit on neighbouring entries
    assert property (@(posedge clk) disable iff (!rst_n)
        retire_out[1].valid |-> retire_out[1].rob_addr == rob_addr_t'(retire_out[0].rob_addr + 1'b1))
        else $error("retire slot 1 address does not follow slot 0");

    assert property (@(posedge clk) disable iff (!rst_n)
        retire_out[1].valid |-> retire_out[0].valid)
        else $error("retire slot 1 valid without slot 0");

    // table is empty right after a redirect
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect.valid |=> !retire_out[0].valid)
        else $error("retire in the cycle after a redirect");

    assert property (@(posedge clk) disable iff (!rst_n)
        mwrite.valid && !d_data_ok |=> mwrite.valid && $stable(mwrite))
        else $error("mwrite changed while waiting for acknowledge");

endmodule

bind rob backend_props i_rob_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .retire_out (retire_out),
    .redirect   (redirect),
    .mwrite     ('0),
    .d_data_ok  (1'b0)
);

bind store_port backend_props i_store_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .retire_out ('0),
    .redirect   ('0),
    .mwrite     (mwrite),
    .d_data_ok  (d_data_ok)
);

// File: bench/tb_backend.sv
module tb_backend
    import core_pkg::*;
    import rob_pkg::*;
;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 120;
    localparam int NUM_TESTS    = 6;

    logic clk;
    logic rst_n;
    rename_slot_t [MACHINE_WIDTH-1:0] rename_in;
    alu_req_t     alu_req;
    mult_req_t    mult_req;
    mem_done_t    mem_done;
    logic         d_data_ok;
    rob_addr_t    [MACHINE_WIDTH-1:0] alloc_addr;
    logic         rob_full;
    retire_slot_t [RETIRE_WIDTH-1:0] retire_out;
    redirect_t    redirect;
    store_req_t   mwrite;

    // reference model state
    rob_addr_t   exp_tail;
    word_t       pc_next;
    reg_addr_t   dst_model [ROB_DEPTH];
    word_t       pc_model  [ROB_DEPTH];
    rob_addr_t   exp_addr_q[$];
    logic [63:0] exp_data_q[$];
    reg_addr_t   exp_dst_q[$];
    word_t       exp_pc_q[$];
    rob_addr_t   ret_addr_q[$];
    logic [63:0] ret_data_q[$];
    reg_addr_t   ret_dst_q[$];
    word_t       ret_pc_q[$];
    word_t       redir_q[$];
    int          errors;
    int          test_start_errors;
    int          tests_passed;
    int          tests_failed;
    string       test_name;

    backend_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rename_in  (rename_in),
        .alu_req    (alu_req),
        .mult_req   (mult_req),
        .mem_done   (mem_done),
        .d_data_ok  (d_data_ok),
        .alloc_addr (alloc_addr),
        .rob_full   (rob_full),
        .retire_out (retire_out),
        .redirect   (redirect),
        .mwrite     (mwrite)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sampled before the edge updates anything
    always @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < RETIRE_WIDTH; i++) begin
                if (retire_out[i].valid) begin
                    ret_addr_q.push_back(retire_out[i].rob_addr);
                    ret_data_q.push_back(retire_out[i].data);
                    ret_dst_q.push_back(retire_out[i].dst);
                    ret_pc_q.push_back(retire_out[i].pc_plus8);
                end
            end
            if (redirect.valid) begin
                redir_q.push_back(redirect.target);
            end
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 50) * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [63:0] alu_expect(op_t op, word_t a, word_t b);
        case (op)
            OP_ADD:  return {32'b0, a + b};
            OP_SUB:  return {32'b0, a - b};
            OP_AND:  return {32'b0, a & b};
            OP_OR:   return {32'b0, a | b};
            OP_XOR:  return {32'b0, a ^ b};
            OP_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: return 64'd0;
        endcase
    endfunction

    function automatic logic [63:0] mult_expect(word_t a, word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = $signed(a);
        sb = $signed(b);
        return sa * sb;
    endfunction

    task automatic check_val(string what, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    // every cycle starts from idle inputs
    task automatic next_cycle();
        @(posedge clk);
        rename_in <= '0;
        alu_req   <= '0;
        mult_req  <= '0;
        mem_done  <= '0;
        d_data_ok <= 1'b0;
    endtask

    task automatic alloc_ops(input int n, input op_t op0, input op_t op1,
                             output rob_addr_t a0, output rob_addr_t a1,
                             output word_t pc0, output word_t pc1);
        rob_addr_t nxt;
        reg_addr_t d0;
        reg_addr_t d1;
        next_cycle();
        pc0 = pc_next + 8;
        pc1 = pc_next + 12;
        nxt = exp_tail + 1'b1;
        d0  = reg_addr_t'($urandom);
        d1  = reg_addr_t'($urandom);
        rename_in[0] <= '{valid: 1'b1, dst: d0, pc_plus8: pc0, op: op0};
        if (n > 1) begin
            rename_in[1] <= '{valid: 1'b1, dst: d1, pc_plus8: pc1, op: op1};
        end
        @(negedge clk);
        a0 = alloc_addr[0];
        a1 = alloc_addr[1];
        if (rob_full || redirect.valid) begin
            report_error("allocation was not accepted");
        end
        check_val("alloc address 0", exp_tail, a0);
        if (n > 1) begin
            check_val("alloc address 1", nxt, a1);
        end
        dst_model[exp_tail] = d0;
        pc_model[exp_tail]  = pc0;
        if (n > 1) begin
            dst_model[nxt] = d1;
            pc_model[nxt]  = pc1;
        end
        exp_tail = exp_tail + rob_addr_t'(n);
        pc_next  = pc_next + word_t'(4 * n);
    endtask

    task automatic expect_retire(rob_addr_t addr, logic [63:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        exp_dst_q.push_back(dst_model[addr]);
        exp_pc_q.push_back(pc_model[addr]);
    endtask

    task automatic issue_alu(rob_addr_t addr, op_t op, word_t a, word_t b, word_t tgt);
        next_cycle();
        alu_req <= '{valid: 1'b1, rob_addr: addr, op: op, a: a, b: b, target: tgt};
    endtask

    task automatic issue_mult(rob_addr_t addr, word_t a, word_t b);
        next_cycle();
        mult_req <= '{valid: 1'b1, rob_addr: addr, a: a, b: b};
    endtask

    task automatic send_mem(rob_addr_t addr, word_t maddr, word_t data);
        next_cycle();
        mem_done <= '{valid: 1'b1, rob_addr: addr, addr: maddr, data: data};
    endtask

    task automatic wait_retired(int n, int limit);
        int cycles;
        cycles = 0;
        while (ret_addr_q.size() < n && cycles < limit) begin
            next_cycle();
            @(negedge clk);
            cycles++;
        end
        if (ret_addr_q.size() < n) begin
            report_error($sformatf("only %0d of %0d instructions retired in time",
                                   ret_addr_q.size(), n));
        end
    endtask

    // retired stream against the model in program order
    task automatic compare_retired();
        if (ret_addr_q.size() != exp_addr_q.size()) begin
            report_error($sformatf("%0d instructions retired, %0d expected",
                                   ret_addr_q.size(), exp_addr_q.size()));
        end
        for (int i = 0; i < ret_addr_q.size() && i < exp_addr_q.size(); i++) begin
            check_val("retire address", exp_addr_q[i], ret_addr_q[i]);
            check_val("retire data", exp_data_q[i], ret_data_q[i]);
            check_val("retire dst", exp_dst_q[i], ret_dst_q[i]);
            check_val("retire pc_plus8", exp_pc_q[i], ret_pc_q[i]);
        end
        ret_addr_q.delete();
        ret_data_q.delete();
        ret_dst_q.delete();
        ret_pc_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_dst_q.delete();
        exp_pc_q.delete();
    endtask

    task automatic start_test(string name);
        test_name         = name;
        test_start_errors = errors;
        redir_q.delete();
    endtask

    task automatic finish_test();
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    task automatic in_order_retire();
        rob_addr_t a[4];
        word_t     pc[4];
        word_t     x[4];
        word_t     y[4];
        op_t       ops[4];
        start_test("in_order");
        ops = '{OP_ADD, OP_SUB, OP_XOR, OP_SLT};
        for (int i = 0; i < 4; i++) begin
            x[i] = $urandom;
            y[i] = $urandom;
        end
        alloc_ops(2, ops[0], ops[1], a[0], a[1], pc[0], pc[1]);
        alloc_ops(2, ops[2], ops[3], a[2], a[3], pc[2], pc[3]);
        for (int i = 0; i < 4; i++) begin
            expect_retire(a[i], alu_expect(ops[i], x[i], y[i]));
        end
        // youngest first
        for (int i = 3; i >= 0; i--) begin
            issue_alu(a[i], ops[i], x[i], y[i], '0);
        end
        wait_retired(4, 10);
        compare_retired();
        finish_test();
    endtask

    task automatic mult_pipelining();
        rob_addr_t a0, a1;
        word_t     pc0, pc1, x0, y0, x1, y1;
        start_test("mult_pipe");
        x0 = $urandom;
        y0 = $urandom;
        x1 = $urandom;
        y1 = $urandom;
        alloc_ops(2, OP_MULT, OP_MULT, a0, a1, pc0, pc1);
        expect_retire(a0, mult_expect(x0, y0));
        expect_retire(a1, mult_expect(x1, y1));
        issue_mult(a0, x0, y0);
        issue_mult(a1, x1, y1);
        // back-to-back multiplies finish within the pipeline depth
        wait_retired(2, 4);
        compare_retired();
        finish_test();
    endtask

    task automatic full_and_hold();
        rob_addr_t a[16];
        word_t     x[16];
        word_t     y[16];
        rob_addr_t dummy;
        word_t     pc, junk;
        int        count;
        logic      full_seen;
        start_test("full_hold");
        count     = 0;
        full_seen = 1'b0;
        while (!full_seen && count < 16) begin
            next_cycle();
            @(negedge clk);
            if (rob_full) begin
                full_seen = 1'b1;
            end else begin
                x[count] = $urandom;
                y[count] = $urandom;
                alloc_ops(1, OP_ADD, OP_ADD, a[count], dummy, pc, junk);
                expect_retire(a[count], alu_expect(OP_ADD, x[count], y[count]));
                count++;
            end
        end
        if (!full_seen) begin
            report_error("rob_full never rose");
        end
        check_val("entries at full", 15, count);
        for (int i = 0; i < count; i++) begin
            issue_alu(a[i], OP_ADD, x[i], y[i], '0);
        end
        wait_retired(count, 30);
        compare_retired();
        next_cycle();
        @(negedge clk);
        if (rob_full) begin
            report_error("rob_full still high after all entries retired");
        end
        x[0] = $urandom;
        y[0] = $urandom;
        alloc_ops(1, OP_AND, OP_AND, a[0], dummy, pc, junk);
        expect_retire(a[0], alu_expect(OP_AND, x[0], y[0]));
        issue_alu(a[0], OP_AND, x[0], y[0], '0);
        wait_retired(1, 6);
        compare_retired();
        finish_test();
    endtask

    task automatic taken_redirect();
        rob_addr_t ab, a1, a2, dummy;
        word_t     pcb, pc1, pc2, junk, tgt, v;
        start_test("redirect");
        alloc_ops(2, OP_BEQ, OP_ADD, ab, a1, pcb, pc1);
        alloc_ops(1, OP_SUB, OP_SUB, a2, dummy, pc2, junk);
        expect_retire(ab, {32'b0, pcb});
        tgt = $urandom;
        v   = $urandom;
        issue_alu(a1, OP_ADD, $urandom, $urandom, '0);
        issue_alu(a2, OP_SUB, $urandom, $urandom, '0);
        issue_alu(ab, OP_BEQ, v, v, tgt);
        wait_retired(1, 6);
        repeat (4) next_cycle();
        @(negedge clk);
        // the two younger ops must not show up here
        compare_retired();
        if (redir_q.size() != 1) begin
            report_error($sformatf("expected one redirect, saw %0d", redir_q.size()));
        end else begin
            check_val("redirect target", tgt, redir_q[0]);
        end
        exp_tail = ab + 1'b1;
        alloc_ops(1, OP_OR, OP_OR, a1, dummy, pc1, junk);
        v = $urandom;
        expect_retire(a1, alu_expect(OP_OR, v, tgt));
        issue_alu(a1, OP_OR, v, tgt, '0);
        wait_retired(1, 6);
        compare_retired();
        finish_test();
    endtask

    task automatic store_backpressure();
        rob_addr_t s0, s1;
        word_t     p0, p1, ad0, ad1, d0, d1;
        int        cycles;
        start_test("store_backpressure");
        ad0 = $urandom;
        ad1 = $urandom;
        d0  = $urandom;
        d1  = $urandom;
        alloc_ops(2, OP_STORE, OP_STORE, s0, s1, p0, p1);
        expect_retire(s0, {32'b0, d0});
        expect_retire(s1, {32'b0, d1});
        send_mem(s0, ad0, d0);
        send_mem(s1, ad1, d1);
        wait_retired(1, 6);
        repeat (6) begin
            next_cycle();
            @(negedge clk);
            check_val("mwrite.valid", 1, mwrite.valid);
            check_val("mwrite.addr", ad0, mwrite.addr);
            check_val("mwrite.data", d0, mwrite.data);
        end
        if (ret_addr_q.size() != 1) begin
            report_error("second store retired while the store port was busy");
        end
        next_cycle();
        d_data_ok <= 1'b1;
        wait_retired(2, 6);
        cycles = 0;
        while (!(mwrite.valid && mwrite.addr == ad1) && cycles < 6) begin
            next_cycle();
            @(negedge clk);
            cycles++;
        end
        check_val("second mwrite.valid", 1, mwrite.valid);
        check_val("second mwrite.addr", ad1, mwrite.addr);
        check_val("second mwrite.data", d1, mwrite.data);
        next_cycle();
        d_data_ok <= 1'b1;
        next_cycle();
        @(negedge clk);
        check_val("mwrite.valid after ack", 0, mwrite.valid);
        compare_retired();
        finish_test();
    endtask

    task automatic not_taken_branch();
        rob_addr_t a, dummy;
        word_t     pc, junk, v;
        start_test("not_taken");
        alloc_ops(1, OP_BNE, OP_BNE, a, dummy, pc, junk);
        expect_retire(a, {32'b0, pc});
        v = $urandom;
        issue_alu(a, OP_BNE, v, v, $urandom);
        wait_retired(1, 6);
        next_cycle();
        @(negedge clk);
        compare_retired();
        if (redir_q.size() != 0) begin
            report_error("not-taken bne raised a redirect");
        end
        finish_test();
    endtask

    initial begin
        void'($urandom(32'h587c));
        rst_n        = 1'b0;
        rename_in    = '0;
        alu_req      = '0;
        mult_req     = '0;
        mem_done     = '0;
        d_data_ok    = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        exp_tail     = '0;
        pc_next      = 32'h0000_1000;
        test_name    = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (retire_out[0].valid || retire_out[1].valid || redirect.valid ||
                mwrite.valid || rob_full) begin
            report_error("outputs not idle after reset");
        end
        in_order_retire();
        mult_pipelining();
        full_and_hold();
        taken_redirect();
        store_backpressure();
        not_taken_branch();
        repeat (2) next_cycle();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: backend.f
common/core_pkg.sv
common/rob_pkg.sv
rob/rob.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/store_port.sv
hdl/backend_top.sv
bench/backend_props.sv
bench/tb_backend.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_backend -f backend.f
out=$(./obj_dir/Vtb_backend) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"
